// File: build.f
+incdir+include
design/tns_pkg.sv
design/tns_credit_fifo.sv
design/tns_encoder.sv
design/tns_decoder.sv
design/tns_result_stage.sv
design/tns_link_top.sv
dv/tns_clock_gen.sv
dv/tb_tns_link.sv

// File: Bender.yml
package:
  name: tns_link

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/tns_pkg.sv
      - design/tns_credit_fifo.sv
      - design/tns_encoder.sv
      - design/tns_decoder.sv
      - design/tns_result_stage.sv
      - design/tns_link_top.sv
  - target: test
    files:
      - dv/tns_clock_gen.sv
      - dv/tb_tns_link.sv

// File: dv/tb_tns_link.sv
`timescale 1ns/1ps

module tb_tns_link
    import tns_pkg::*;
;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 4;
    localparam int OUT_DEPTH   = 4;
    localparam int LIMIT       = 2000;

    // Sink behavior
    localparam int SINK_RANDOM = 0;
    localparam int SINK_HOLD   = 1;
    localparam int SINK_FAST   = 2;

    logic      clock;
    logic      rst_n;
    logic      in_valid;
    tns_data_t in_data;
    logic      out_credit;
    logic      in_credit;
    logic      out_valid;
    tns_code_t out_code;
    tns_data_t out_data;

    integer    seed;
    longint    w [CODE_W];
    longint    low [CODE_W];
    logic [GROUP_N-1:0] ref_hist;
    tns_data_t exp_data_q [$];
    tns_code_t exp_code_q [$];
    tns_data_t exp_data;
    tns_code_t exp_code;
    logic      exp_pending;
    int        src_credits;
    int        sent;
    int        out_count;
    int        ret_count;
    int        in_cred_count;
    int        owed;
    int        sink_mode;
    int        errors;
    int        timeouts;
    logic      timed_out;
    logic      started;
    logic      lat_check;

    tns_clock_gen u_clk (
        .clock (clock),
        .rst_n (rst_n)
    );

    tns_link_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .OUT_DEPTH   (OUT_DEPTH)
    ) u_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_code   (out_code),
        .out_data   (out_data)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Each weight is the sum of the three below it
    task automatic build_weights;
        w[0]   = 1;
        w[1]   = 2;
        w[2]   = 4;
        low[0] = 0;
        for (int k = 3; k < CODE_W; k++) begin
            w[k] = w[k-1] + w[k-2] + w[k-3];
        end
        for (int k = 1; k < CODE_W; k++) begin
            low[k] = low[k-1] + w[k-1];
        end
    endtask

    function automatic longint code_value(input tns_code_t c);
        longint s;
        s = 0;
        for (int k = 0; k < CODE_W; k++) begin
            if (c[k]) begin
                s += w[k];
            end
        end
        return s;
    endfunction

    task automatic encode_ref(input tns_data_t d, output tns_code_t c);
        longint rem;
        rem = d;
        c   = '0;
        for (int pos = CODE_W - 1; pos >= 1; pos--) begin
            // Free choice at a group top copies the last accepted word
            if (pos % 3 == 2 && rem >= w[pos] && rem <= low[pos]) begin
                c[pos] = ref_hist[pos / 3];
            end else begin
                c[pos] = (rem >= w[pos]);
            end
            if (c[pos]) begin
                rem -= w[pos];
            end
        end
        c[0] = (rem == 1);
        for (int g = 0; g < GROUP_N; g++) begin
            ref_hist[g] = c[3 * g + 2];
        end
    endtask

    task automatic refresh_head;
        exp_pending = (exp_data_q.size() != 0);
        if (exp_pending) begin
            exp_data = exp_data_q[0];
            exp_code = exp_code_q[0];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor and sink
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (in_credit) begin
            in_cred_count++;
            src_credits++;
        end
        if (out_credit) begin
            ret_count++;
        end
        if (out_valid) begin
            out_count++;
            owed++;
            if (exp_data_q.size() != 0) begin
                void'(exp_data_q.pop_front());
                void'(exp_code_q.pop_front());
            end
            refresh_head();
        end
    end

    // Returns one credit per received word at a rate set by sink_mode
    always @(posedge clock) begin
        #1;
        out_credit = 1'b0;
        if (rst_n && owed > 0) begin
            if (sink_mode == SINK_FAST ||
                (sink_mode == SINK_RANDOM && ($random(seed) & 3) != 0)) begin
                out_credit = 1'b1;
                owed--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_quiet: assert property (@(posedge clock) disable iff (!rst_n)
        !started |-> !in_credit && !out_valid)
        else begin
            errors++;
            $display("error at %0t ns: credit or output activity before the first word", $time);
        end

    a_order: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> exp_pending && out_data == exp_data)
        else begin
            errors++;
            $display("error at %0t ns: out_data %h, expected %h",
                     $time, $sampled(out_data), $sampled(exp_data));
        end

    a_code: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> out_code == exp_code)
        else begin
            errors++;
            $display("error at %0t ns: out_code %h, expected %h",
                     $time, $sampled(out_code), $sampled(exp_code));
        end

    a_sum: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> code_value(out_code) == longint'(out_data))
        else begin
            errors++;
            $display("error at %0t ns: code %h weighs %0d, data is %0d", $time,
                     $sampled(out_code), code_value($sampled(out_code)), $sampled(out_data));
        end

    a_out_credit: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> out_count < ret_count + OUT_CREDITS)
        else begin
            errors++;
            $display("error at %0t ns: out_valid without a sink credit", $time);
        end

    a_in_credit: assert property (@(posedge clock) disable iff (!rst_n)
        in_credit |-> in_cred_count < sent)
        else begin
            errors++;
            $display("error at %0t ns: in_credit for a word never sent", $time);
        end

    // Encoder, decoder and output FIFO each add one cycle
    a_latency: assert property (@(posedge clock) disable iff (!rst_n)
        lat_check && u_dut.enc_valid |-> ##3 out_valid)
        else begin
            errors++;
            $display("error at %0t ns: no out_valid three cycles after a pop", $time);
        end

    ////////////////////////////////////////////////////////////
    // Source and waits
    ////////////////////////////////////////////////////////////

    task automatic report_timeout(input string what);
        timeouts++;
        timed_out = 1'b1;
        $display("timeout: %s did not finish within %0d cycles", what, LIMIT);
    endtask

    task automatic wait_reset;
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (!rst_n) begin
            report_timeout("reset release");
        end
        @(posedge clock);
        #1;
    endtask

    task automatic send_word(input tns_data_t d);
        int        cycles;
        tns_code_t c;
        if (timed_out) begin
            return;
        end
        cycles = 0;
        while (src_credits == 0 && cycles < LIMIT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (src_credits == 0) begin
            report_timeout("source waiting for an input credit");
            return;
        end
        encode_ref(d, c);
        exp_data_q.push_back(d);
        exp_code_q.push_back(c);
        refresh_head();
        src_credits--;
        sent++;
        started  = 1'b1;
        in_valid = 1'b1;
        in_data  = d;
        @(posedge clock);
        #1;
        in_valid = 1'b0;
    endtask

    // Input credits are left out here so the closing check can catch a lost one
    function automatic logic drain_pending();
        return exp_data_q.size() != 0 || owed != 0;
    endfunction

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while (!timed_out && drain_pending() && cycles < LIMIT) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!timed_out && drain_pending()) begin
            report_timeout(what);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        int k;
        seed          = 87;
        in_valid      = 1'b0;
        in_data       = '0;
        out_credit    = 1'b0;
        ref_hist      = '0;
        exp_data      = '0;
        exp_code      = '0;
        exp_pending   = 1'b0;
        src_credits   = IN_DEPTH;
        sent          = 0;
        out_count     = 0;
        ret_count     = 0;
        in_cred_count = 0;
        owed          = 0;
        sink_mode     = SINK_RANDOM;
        errors        = 0;
        timeouts      = 0;
        timed_out     = 1'b0;
        started       = 1'b0;
        lat_check     = 1'b0;
        build_weights();

        wait_reset();
        // Quiet window before the first word
        repeat (4) @(posedge clock);
        #1;

        send_word('0);
        send_word('1);
        for (k = 0; k < CODE_W; k++) begin
            send_word(tns_data_t'(w[k]));
            send_word(tns_data_t'(w[k] - 1));
        end
        wait_drain("corner values");

        // Force each group top to 1, then to 0, each followed by a free choice
        for (k = 5; k < CODE_W; k += 3) begin
            send_word(tns_data_t'(low[k] + 1));
            send_word(tns_data_t'((w[k] + low[k]) / 2));
            send_word(tns_data_t'(w[k] - 1));
            send_word(tns_data_t'((w[k] + low[k]) / 2));
        end
        wait_drain("free choice pairs");

        repeat (200) send_word(tns_data_t'($random(seed)));
        wait_drain("random words");

        // Twelve words fill the whole link while the sink holds its credits
        sink_mode = SINK_HOLD;
        repeat (12) send_word(tns_data_t'($random(seed)));
        repeat (20) @(posedge clock);
        #1;
        sink_mode = SINK_RANDOM;
        wait_drain("back-pressure recovery");

        sink_mode = SINK_FAST;
        lat_check = 1'b1;
        repeat (40) send_word(tns_data_t'($random(seed)));
        wait_drain("streaming words");
        repeat (4) @(posedge clock);
        #1;
        lat_check = 1'b0;

        a_credits_home: assert (in_cred_count == sent && src_credits == IN_DEPTH)
            else begin
                errors++;
                $display("error at %0t ns: %0d input credits back for %0d words, %0d held",
                         $time, in_cred_count, sent, src_credits);
            end

        $display("summary: %0d words sent, %0d received, %0d failed checks, %0d timeouts",
                 sent, out_count, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: dv/tns_clock_gen.sv
`timescale 1ns/1ps

module tns_clock_gen (
    output logic clock,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset held for five rising edges, released just after the fifth
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: design/tns_link_top.sv
`timescale 1ns/1ps

module tns_link_top
    import tns_pkg::*;
#(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 4,
    parameter int OUT_DEPTH   = 4
) (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,
    input  tns_data_t in_data,
    input  logic      out_credit,
    output logic      in_credit,
    output logic      out_valid,
    output tns_code_t out_code,
    output tns_data_t out_data
);

    logic      in_empty;
    logic      issue_ok;
    logic      enc_valid;
    tns_data_t enc_data;
    logic      code_valid;
    tns_code_t code;
    logic      pair_valid;
    tns_code_t pair_code;
    tns_data_t pair_data;

    // A word issues as soon as the output side can take it
    assign enc_valid = issue_ok && !in_empty;

    ////////////////////////////////////////////////////////////
    // Input buffer
    ////////////////////////////////////////////////////////////

    tns_credit_fifo #(
        .payload_t (tns_data_t),
        .DEPTH     (IN_DEPTH)
    ) u_in_buf (
        .clock     (clock),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_data),
        .pop       (enc_valid),
        .pop_data  (enc_data),
        .empty     (in_empty),
        .credit    (in_credit),
        .count     ()
    );

    ////////////////////////////////////////////////////////////
    // Encoder and decoder
    ////////////////////////////////////////////////////////////

    tns_encoder u_enc (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (enc_valid),
        .in_data   (enc_data),
        .out_valid (code_valid),
        .out_code  (code)
    );

    tns_decoder u_dec (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (code_valid),
        .in_code   (code),
        .out_valid (pair_valid),
        .out_code  (pair_code),
        .out_data  (pair_data)
    );

    ////////////////////////////////////////////////////////////
    // Output credit stage
    ////////////////////////////////////////////////////////////

    tns_result_stage #(
        .OUT_CREDITS (OUT_CREDITS),
        .OUT_DEPTH   (OUT_DEPTH)
    ) u_res (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (pair_valid),
        .in_code    (pair_code),
        .in_data    (pair_data),
        .issue      (enc_valid),
        .out_credit (out_credit),
        .issue_ok   (issue_ok),
        .out_valid  (out_valid),
        .out_code   (out_code),
        .out_data   (out_data)
    );

endmodule

// File: design/tns_result_stage.sv
`timescale 1ns/1ps

module tns_result_stage
    import tns_pkg::*;
#(
    parameter int OUT_CREDITS = 4,
    parameter int OUT_DEPTH   = 4
) (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,
    input  tns_code_t in_code,
    input  tns_data_t in_data,
    input  logic      issue,
    input  logic      out_credit,
    output logic      issue_ok,
    output logic      out_valid,
    output tns_code_t out_code,
    output tns_data_t out_data
);

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);
    localparam int RSV_W  = $clog2(OUT_DEPTH + 1);

    logic [CRED_W-1:0] cred_cnt;
    logic [RSV_W-1:0]  rsv_cnt;
    tns_pair_t         push_pair;
    tns_pair_t         head_pair;
    logic              fifo_empty;
    logic              slot_free;
    logic              send;

    assign push_pair = '{code: in_code, data: in_data};

    tns_credit_fifo #(
        .payload_t (tns_pair_t),
        .DEPTH     (OUT_DEPTH)
    ) u_out_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (push_pair),
        .pop       (send),
        .pop_data  (head_pair),
        .empty     (fifo_empty),
        .credit    (slot_free),
        .count     ()
    );

    // Send the head word whenever the sink has room
    assign send      = !fifo_empty && (cred_cnt != '0);
    assign out_valid = send;
    assign out_code  = head_pair.code;
    assign out_data  = head_pair.data;

    // Slots are held from issue until the word leaves the FIFO
    assign issue_ok  = (rsv_cnt < RSV_W'(OUT_DEPTH));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cred_cnt <= CRED_W'(OUT_CREDITS);
            rsv_cnt  <= '0;
        end else begin
            case ({send, out_credit})
                2'b10:   cred_cnt <= cred_cnt - CRED_W'(1);
                2'b01:   cred_cnt <= cred_cnt + CRED_W'(1);
                default: cred_cnt <= cred_cnt;
            endcase
            case ({issue, slot_free})
                2'b10:   rsv_cnt <= rsv_cnt + RSV_W'(1);
                2'b01:   rsv_cnt <= rsv_cnt - RSV_W'(1);
                default: rsv_cnt <= rsv_cnt;
            endcase
        end
    end

endmodule

// File: design/tns_decoder.sv
`timescale 1ns/1ps

module tns_decoder
    import tns_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,
    input  tns_code_t in_code,
    output logic      out_valid,
    output tns_code_t out_code,
    output tns_data_t out_data
);

    tns_data_t sum;

    // Weighted sum of all set code bits
    always_comb begin
        sum = '0;
        for (int k = 0; k < CODE_W; k++) begin
            if (in_code[k]) begin
                sum = sum + TNS_W[k][DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Code travels with its data so both arrive together
    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_code <= in_code;
            out_data <= sum;
        end
    end

endmodule

// File: design/tns_encoder.sv
`timescale 1ns/1ps

module tns_encoder
    import tns_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,
    input  tns_data_t in_data,
    output logic      out_valid,
    output tns_code_t out_code
);

    ////////////////////////////////////////////////////////////
    // Remainder chain and code bits
    ////////////////////////////////////////////////////////////

    logic [WEIGHT_W-1:0] rem;
    tns_code_t           code_c;

    // Group-top bits of the last accepted code word
    logic [GROUP_N-1:0]  hist;

    // Walks from the top bit down, subtracting each chosen weight
    always_comb begin
        rem    = WEIGHT_W'(in_data);
        code_c = '0;
        for (int k = CODE_W - 1; k > 0; k--) begin
            if ((k % GROUP_SPAN == GROUP_TOP_OFS) &&
                (rem >= TNS_W[k]) && (rem <= TNS_LOW_SUM[k])) begin
                // Either choice works here, so avoid a transition
                code_c[k] = hist[k / GROUP_SPAN];
            end else begin
                code_c[k] = (rem >= TNS_W[k]);
            end
            if (code_c[k]) begin
                rem = rem - TNS_W[k];
            end
        end
        // At most one is left for the unit weight
        code_c[0] = rem[0];
    end

    ////////////////////////////////////////////////////////////
    // Output register and history
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            hist      <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                for (int g = 0; g < GROUP_N; g++) begin
                    hist[g] <= code_c[g * GROUP_SPAN + GROUP_TOP_OFS];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_code <= code_c;
        end
    end

endmodule

// File: design/tns_credit_fifo.sv
`timescale 1ns/1ps

module tns_credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     pop_data,
    output logic                         empty,
    output logic                         credit,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic     [PTR_W-1:0] wr_ptr;
    logic     [PTR_W-1:0] rd_ptr;
    logic                 full;
    logic                 wr_en;
    logic                 rd_en;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // A push into a full FIFO still lands when a pop frees the slot
    assign rd_en = pop && !empty;
    assign wr_en = push && (!full || rd_en);

    // Head of the queue is visible before the pop
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end

            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase

            // One credit back per word that left
            credit <= rd_en;
        end
    end

endmodule

// File: design/tns_pkg.sv
package tns_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_W   = 24;
    localparam int CODE_W   = 28;

    // Weights and lower sums need one bit more than a data word
    localparam int WEIGHT_W = 25;

    ////////////////////////////////////////////////////////////
    // Group geometry
    ////////////////////////////////////////////////////////////

    // Three bits per group, the top bit of a group carries history
    localparam int GROUP_SPAN    = 3;
    localparam int GROUP_TOP_OFS = 2;
    localparam int GROUP_N       = 9;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [DATA_W-1:0] tns_data_t;
    typedef logic [CODE_W-1:0] tns_code_t;

    typedef struct packed {
        tns_code_t code;
        tns_data_t data;
    } tns_pair_t;

    `include "tns_weights.svh"

endpackage

// File: include/tns_weights.svh
`ifndef TNS_WEIGHTS_SVH
`define TNS_WEIGHTS_SVH

// Tribonacci weight of each code bit, bit 0 first
localparam logic [WEIGHT_W-1:0] TNS_W [CODE_W] = '{
    25'd1,       25'd2,       25'd4,       25'd7,
    25'd13,      25'd24,      25'd44,      25'd81,
    25'd149,     25'd274,     25'd504,     25'd927,
    25'd1705,    25'd3136,    25'd5768,    25'd10609,
    25'd19513,   25'd35890,   25'd66012,   25'd121415,
    25'd223317,  25'd410744,  25'd755476,  25'd1389537,
    25'd2555757, 25'd4700770, 25'd8646064, 25'd15902591
};

// Entry k holds the sum of all weights below bit k
// This is the largest remainder the lower bits can still absorb
localparam logic [WEIGHT_W-1:0] TNS_LOW_SUM [CODE_W] = '{
    25'd0,       25'd1,        25'd3,        25'd7,
    25'd14,      25'd27,       25'd51,       25'd95,
    25'd176,     25'd325,      25'd599,      25'd1103,
    25'd2030,    25'd3735,     25'd6871,     25'd12639,
    25'd23248,   25'd42761,    25'd78651,    25'd144663,
    25'd266078,  25'd489395,   25'd900139,   25'd1655615,
    25'd3045152, 25'd5600909,  25'd10301679, 25'd18947743
};

`endif
